//--- build.f
+incdir+src
src/exePkg.sv
src/alu.sv
src/mulDiv.sv
src/branchUnit.sv
src/memAddrUnit.sv
src/resultSelect.sv
src/exeStage.sv
test/exeStageTb.sv

//--- Bender.yml
package:
  name: exe_stage

sources:
  - include_dirs:
      - src
    files:
      - src/exePkg.sv
      - src/alu.sv
      - src/mulDiv.sv
      - src/branchUnit.sv
      - src/memAddrUnit.sv
      - src/resultSelect.sv
      - src/exeStage.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/exeStageTb.sv

//--- test/exeStageTb.sv
`include "exeStage_cfg.svh"

module exeStageTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClkPeriod = 20;
	localparam int ResetCycles = 8;
	localparam int PhaseLen = 64;
	localparam int NumStim = 6 * PhaseLen; // alu, muldiv, branch, mem, select, mixed
	localparam int DrainCycles = 2;

	// expected outputs for one bundle
	typedef struct packed {
		exePkg::exeResult_t wb;
		exePkg::memReq_t mem;
		logic [`XLEN-1:0] target;
		logic taken;
		logic ctrl; // target is only meaningful for valid control flow
	} expect_t;

	logic clk;
	logic nrst;
	exePkg::exeIssue_t issue;
	exePkg::exeResult_t wb;
	exePkg::memReq_t memReq;
	logic [`XLEN-1:0] target;
	logic bjTaken;

	int errors;
	int checks;
	expect_t brLine[$]; // 1 deep
	expect_t wbLine[$]; // 2 deep

	exeStage uut (
		.clk     (clk),
		.nrst    (nrst),
		.issue   (issue),
		.wb      (wb),
		.memReq  (memReq),
		.target  (target),
		.bjTaken (bjTaken)
	);

	initial clk = 1'b0;
	always #(ClkPeriod / 2) clk = ~clk;

	function automatic exePkg::aluOp_e aluOpAt(int k);
		if (k < 8)
			return exePkg::aluOp_e'(k); // encodings 0..7 are all defined
		else if (k == 8)
			return exePkg::ALU_SUB;
		else
			return exePkg::ALU_SRA;
	endfunction

	function automatic exePkg::brCond_e brCondAt(int k);
		return exePkg::brCond_e'(k < 2 ? k : k + 2); // skips the two reserved codes
	endfunction

	function automatic logic [`XLEN-1:0] aluModel(logic [`XLEN-1:0] a, logic [`XLEN-1:0] b,
		exePkg::aluOp_e op);
		logic [4:0] sh;
		logic [`XLEN-1:0] ones;
		sh = b[4:0];
		ones = '1;
		case (op)
			exePkg::ALU_ADD:  return a + b;
			exePkg::ALU_SUB:  return a - b;
			exePkg::ALU_SLL:  return a << sh;
			exePkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
			exePkg::ALU_SLTU: return (a < b) ? 1 : 0;
			exePkg::ALU_XOR:  return a ^ b;
			exePkg::ALU_SRL:  return a >> sh;
			exePkg::ALU_SRA:  return (a >> sh) | (a[`XLEN-1] ? ~(ones >> sh) : '0); // sign fill
			exePkg::ALU_OR:   return a | b;
			exePkg::ALU_AND:  return a & b;
			default:          return '0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] mulDivModel(logic [`XLEN-1:0] a, logic [`XLEN-1:0] b,
		exePkg::mulDivOp_e op);
		logic signed [2*`XLEN-1:0] sa;
		logic signed [2*`XLEN-1:0] sb;
		logic signed [2*`XLEN-1:0] ub;
		logic [2*`XLEN-1:0] p;
		logic signed [`XLEN-1:0] q;
		logic overflow;
		sa = {{`XLEN{a[`XLEN-1]}}, a};
		sb = {{`XLEN{b[`XLEN-1]}}, b};
		ub = {{`XLEN{1'b0}}, b};
		overflow = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);
		case (op)
			exePkg::MD_MUL: p = a * b;
			exePkg::MD_MULH: p = sa * sb;
			exePkg::MD_MULHSU: p = sa * ub;
			exePkg::MD_MULHU: p = {{`XLEN{1'b0}}, a} * ub;
			default: p = '0;
		endcase
		case (op)
			exePkg::MD_MUL: return p[`XLEN-1:0];
			exePkg::MD_MULH, exePkg::MD_MULHSU, exePkg::MD_MULHU: return p[2*`XLEN-1:`XLEN];
			exePkg::MD_DIV:
			begin
				if (b == '0)
					return '1;
				if (overflow)
					return a;
				q = $signed(a) / $signed(b); // truncates toward zero
				return q;
			end
			exePkg::MD_DIVU: return (b == '0) ? '1 : a / b;
			exePkg::MD_REM:
			begin
				if (b == '0)
					return a;
				if (overflow)
					return '0;
				q = $signed(a) % $signed(b); // sign follows the dividend
				return q;
			end
			default: return (b == '0) ? a : a % b;
		endcase
	endfunction

	function automatic logic branchCond(logic [`XLEN-1:0] a, logic [`XLEN-1:0] b,
		exePkg::brCond_e c);
		case (c)
			exePkg::BR_EQ:  return a == b;
			exePkg::BR_NE:  return a != b;
			exePkg::BR_LT:  return $signed(a) < $signed(b);
			exePkg::BR_GE:  return $signed(a) >= $signed(b);
			exePkg::BR_LTU: return a < b;
			exePkg::BR_GEU: return a >= b;
			default:        return 1'b0;
		endcase
	endfunction

	function automatic exePkg::memReq_t memModel(exePkg::memOp_e op, logic [`XLEN-1:0] base,
		logic [`XLEN-1:0] rs2OrImm, logic [`XLEN-1:0] sImm);
		exePkg::memReq_t m;
		logic isLd;
		logic isSt;
		int bytes;
		logic [`XLEN-1:0] a;
		m = '0;
		case (op)
			exePkg::MEM_LB, exePkg::MEM_LBU, exePkg::MEM_SB: bytes = 1;
			exePkg::MEM_LH, exePkg::MEM_LHU, exePkg::MEM_SH: bytes = 2;
			exePkg::MEM_LW, exePkg::MEM_SW: bytes = 4;
			default: bytes = 0;
		endcase
		isSt = op inside {exePkg::MEM_SB, exePkg::MEM_SH, exePkg::MEM_SW};
		isLd = (bytes != 0) && !isSt;
		a = base + (isSt ? sImm : rs2OrImm);
		m.valid = isLd | isSt;
		m.write = isSt;
		m.addr = a;
		m.wdata = rs2OrImm << (8 * a[1:0]);
		m.misaligned = (bytes != 0) && (a % bytes != 0);
		m.ldMisaligned = isLd & m.misaligned;
		m.stMisaligned = isSt & m.misaligned;
		if (bytes != 0 && !m.misaligned)
			m.byteEn = 4'(((1 << bytes) - 1) << a[1:0]);
		return m;
	endfunction

	// whole-stage reference for one issued bundle
	function automatic expect_t predict(exePkg::exeIssue_t b);
		expect_t e;
		e = '0;
		e.wb.we = b.valid & b.we & (b.rd != '0);
		e.wb.rd = b.rd;
		case (b.wbSel)
			exePkg::WB_ALU:    e.wb.data = aluModel(b.opA, b.opB, b.aluOp);
			exePkg::WB_LINK:   e.wb.data = b.pc + 4;
			exePkg::WB_MULDIV: e.wb.data = mulDivModel(b.opA, b.opB, b.mulDivOp);
			exePkg::WB_LUI:    e.wb.data = b.uImm;
			exePkg::WB_AUIPC:  e.wb.data = b.pc + b.uImm;
			default:           e.wb.data = '0;
		endcase
		e.taken = b.valid & (b.isJal | b.isJalr
			| (b.isBranch & branchCond(b.opA, b.opB, b.brCond)));
		e.ctrl = b.valid & (b.isBranch | b.isJal | b.isJalr);
		if (b.isJal)
			e.target = b.pc + b.jImm;
		else if (b.isJalr)
			e.target = (b.opA + b.opB) & ~`XLEN'd1;
		else
			e.target = b.pc + b.bImm;
		e.mem = memModel(b.valid ? b.memOp : exePkg::MEM_NONE, b.opA, b.opB, b.sImm);
		return e;
	endfunction

	function automatic exePkg::exeIssue_t makeBundle(int mode, int idx);
		exePkg::exeIssue_t b;
		logic [`XLEN-1:0] r;
		int kind;
		b = '0;
		b.valid = 1'b1;
		b.we = 1'b1;
		b.opA = $urandom();
		b.opB = $urandom();
		b.rd = `REG_ADDR_W'($urandom());
		r = $urandom();
		b.pc = {r[`XLEN-1:2], 2'b00};
		r = $urandom();
		b.bImm = {{(`XLEN-13){r[12]}}, r[12:1], 1'b0};
		b.jImm = {{(`XLEN-21){r[20]}}, r[20:1], 1'b0};
		b.sImm = {{(`XLEN-12){r[11]}}, r[11:0]};
		r = $urandom();
		b.uImm = {r[`XLEN-1:12], 12'h000};
		b.aluOp = aluOpAt($urandom() % 10);
		b.brCond = brCondAt($urandom() % 6);
		b.mulDivOp = exePkg::mulDivOp_e'($urandom() % 8);
		b.wbSel = exePkg::WB_ALU;
		case (mode)
			0:
			begin
				b.aluOp = aluOpAt(idx % 10);
				if (idx % 7 == 0)
					b.opB = b.opA; // equal operands for the compares
			end
			1:
			begin
				b.wbSel = exePkg::WB_MULDIV;
				b.mulDivOp = exePkg::mulDivOp_e'(idx % 8);
				if ((idx / 8) % 4 == 0)
					b.opB = '0; // zero divisor
				else if ((idx / 8) % 4 == 1)
				begin
					b.opA = {1'b1, {(`XLEN-1){1'b0}}};
					b.opB = '1;
				end
			end
			2:
			begin
				kind = $urandom() % 4;
				b.isBranch = (kind == 0) || (kind == 3);
				b.isJal = kind == 1;
				b.isJalr = kind == 2;
				b.brCond = brCondAt(idx % 6);
				if ($urandom() % 3 == 0)
					b.opB = b.opA;
				b.valid = ($urandom() % 4) != 0;
				b.wbSel = exePkg::WB_LINK;
				b.we = b.isJal | b.isJalr;
			end
			3:
			begin
				b.memOp = exePkg::memOp_e'(1 + $urandom() % 8);
				if (b.memOp inside {exePkg::MEM_LB, exePkg::MEM_LH, exePkg::MEM_LW,
					exePkg::MEM_LBU, exePkg::MEM_LHU})
					b.opB = b.sImm ^ `XLEN'(idx); // small I offset
				if ($urandom() % 2 == 0)
				begin
					b.opA[1:0] = 2'b00; // mostly aligned half the time
					b.sImm[1:0] = 2'b00;
					if (!(b.memOp inside {exePkg::MEM_SB, exePkg::MEM_SH, exePkg::MEM_SW}))
						b.opB[1:0] = 2'b00;
				end
				b.valid = ($urandom() % 8) != 0;
			end
			4:
			begin
				kind = $urandom() % 3;
				b.wbSel = exePkg::wbSel_e'(kind == 0 ? 1 : kind + 2); // link, lui, auipc
				if (idx % 4 == 0)
					b.rd = '0;
				b.valid = ($urandom() % 4) != 0;
			end
			default:
			begin
				kind = $urandom() % 4;
				b.wbSel = exePkg::wbSel_e'($urandom() % 5);
				b.memOp = exePkg::memOp_e'($urandom() % 9);
				b.isBranch = kind == 1;
				b.isJal = kind == 2;
				b.isJalr = kind == 3;
				b.we = $urandom() % 2;
				b.valid = ($urandom() % 4) != 0;
			end
		endcase
		return b;
	endfunction

	task automatic compareValue(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] t=%0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic resetStateCheck();
		compareValue(wb.we, 0, "wb.we in reset");
		compareValue(memReq.valid, 0, "memReq.valid in reset");
		compareValue(memReq.write, 0, "memReq.write in reset");
		compareValue(memReq.byteEn, 0, "byteEn in reset");
		compareValue(memReq.misaligned, 0, "misaligned in reset");
		compareValue(memReq.ldMisaligned, 0, "ldMisaligned in reset");
		compareValue(memReq.stMisaligned, 0, "stMisaligned in reset");
		compareValue(bjTaken, 0, "bjTaken in reset");
	endtask

	task automatic pipelineOutputsCheck(input expect_t eWb, input expect_t eBr);
		compareValue(wb.we, eWb.wb.we, "wb.we");
		if (eWb.wb.we)
		begin
			compareValue(wb.rd, eWb.wb.rd, "wb.rd");
			compareValue(wb.data, eWb.wb.data, "wb.data");
		end
		compareValue(memReq.valid, eWb.mem.valid, "memReq.valid");
		compareValue(memReq.write, eWb.mem.write, "memReq.write");
		compareValue(memReq.byteEn, eWb.mem.byteEn, "memReq.byteEn");
		compareValue(memReq.misaligned, eWb.mem.misaligned, "memReq.misaligned");
		compareValue(memReq.ldMisaligned, eWb.mem.ldMisaligned, "memReq.ldMisaligned");
		compareValue(memReq.stMisaligned, eWb.mem.stMisaligned, "memReq.stMisaligned");
		if (eWb.mem.valid)
		begin
			compareValue(memReq.addr, eWb.mem.addr, "memReq.addr");
			compareValue(memReq.wdata, eWb.mem.wdata, "memReq.wdata");
		end
		compareValue(bjTaken, eBr.taken, "bjTaken");
		if (eBr.ctrl)
			compareValue(target, eBr.target, "target");
	endtask

	initial
	begin
		exePkg::exeIssue_t next;
		expect_t eWb;
		expect_t eBr;
		errors = 0;
		checks = 0;
		nrst = 1'b0;
		issue = '0;
		void'($urandom(39));
		repeat (ResetCycles)
		begin
			@(posedge clk);
			#1;
			resetStateCheck();
		end
		nrst = 1'b1;
		// pipeline holds zero bundles right after reset
		brLine.push_back(predict('0));
		wbLine.push_back(predict('0));
		wbLine.push_back(predict('0));
		for (int i = 0; i < NumStim + DrainCycles; i++)
		begin
			@(posedge clk);
			#1;
			eBr = brLine.pop_front();
			eWb = wbLine.pop_front();
			pipelineOutputsCheck(eWb, eBr);
			if (i < NumStim)
				next = makeBundle(i / PhaseLen, i);
			else
				next = '0; // drain
			issue = next;
			brLine.push_back(predict(next));
			wbLine.push_back(predict(next));
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		#((ResetCycles + NumStim + DrainCycles + 20) * ClkPeriod);
		$display("timeout: the run did not reach its end in the expected time");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- src/exeStage.sv
`include "exeStage_cfg.svh"

module exeStage (
	input logic clk,
	input logic nrst,
	input exePkg::exeIssue_t issue,
	output exePkg::exeResult_t wb,
	output exePkg::memReq_t memReq,
	output logic [`XLEN-1:0] target,
	output logic bjTaken
);

	exePkg::exeIssue_t issueNext;
	exePkg::exeIssue_t issueReg5;

	logic [`XLEN-1:0] aluRes;
	logic brTrue;
	logic [`XLEN-1:0] mulDivRes;

	// a bubble must not write a register or touch memory
	always_comb
	begin
		issueNext = issue;
		if (!issue.valid)
		begin
			issueNext.we = 1'b0;
			issueNext.memOp = exePkg::MEM_NONE;
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			issueReg5 <= '0;
		else
			issueReg5 <= issueNext; // stage 5
	end

	alu exeAlu (
		.opA    (issueReg5.opA),
		.opB    (issueReg5.opB),
		.aluOp  (issueReg5.aluOp),
		.brCond (issueReg5.brCond),
		.result (aluRes),
		.brTrue (brTrue)
	);

	mulDiv exeMulDiv (
		.opA      (issueReg5.opA),
		.opB      (issueReg5.opB),
		.mulDivOp (issueReg5.mulDivOp),
		.result   (mulDivRes)
	);

	branchUnit exeBranch (
		.pc       (issueReg5.pc),
		.opA      (issueReg5.opA),
		.bImm     (issueReg5.bImm),
		.jImm     (issueReg5.jImm),
		.iImm     (issueReg5.opB), // I immediate rides on opB for jalr
		.isBranch (issueReg5.isBranch),
		.isJal    (issueReg5.isJal),
		.isJalr   (issueReg5.isJalr),
		.brTrue   (brTrue),
		.valid    (issueReg5.valid),
		.target   (target),
		.bjTaken  (bjTaken)
	);

	// opB is the load offset or the store source, depending on memOp
	memAddrUnit exeMemAddr (
		.clk       (clk),
		.nrst      (nrst),
		.memOp     (issueReg5.memOp),
		.base      (issueReg5.opA),
		.ldOffset  (issueReg5.opB),
		.sImm      (issueReg5.sImm),
		.storeData (issueReg5.opB),
		.memReq    (memReq)
	);

	resultSelect exeResult (
		.clk       (clk),
		.nrst      (nrst),
		.aluRes    (aluRes),
		.mulDivRes (mulDivRes),
		.pc        (issueReg5.pc),
		.uImm      (issueReg5.uImm),
		.wbSel     (issueReg5.wbSel),
		.rd        (issueReg5.rd),
		.we        (issueReg5.we),
		.valid     (issueReg5.valid),
		.wb        (wb)
	);

endmodule

//--- src/resultSelect.sv
`include "exeStage_cfg.svh"

module resultSelect (
	input logic clk,
	input logic nrst,
	input logic [`XLEN-1:0] aluRes,
	input logic [`XLEN-1:0] mulDivRes,
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] uImm,
	input exePkg::wbSel_e wbSel,
	input logic [`REG_ADDR_W-1:0] rd,
	input logic we,
	input logic valid,
	output exePkg::exeResult_t wb
);

	logic weReg;
	logic [`REG_ADDR_W-1:0] rdReg;
	exePkg::wbSel_e wbSelReg;
	logic [`XLEN-1:0] aluReg;
	logic [`XLEN-1:0] mulDivReg;
	logic [`XLEN-1:0] linkReg;
	logic [`XLEN-1:0] uImmReg;
	logic [`XLEN-1:0] auipcReg;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			weReg <= 1'b0;
			rdReg <= '0;
			wbSelReg <= exePkg::WB_ALU;
		end
		else
		begin
			weReg <= valid & we & (rd != '0); // x0 is never written
			rdReg <= rd;
			wbSelReg <= wbSel;
		end
	end

	always_ff @(posedge clk)
	begin
		aluReg <= aluRes;
		mulDivReg <= mulDivRes;
		linkReg <= pc + `PC_STEP;
		uImmReg <= uImm;
		auipcReg <= pc + uImm;
	end

	always_comb
	begin
		wb.we = weReg;
		wb.rd = rdReg;
		unique case (wbSelReg)
			exePkg::WB_ALU:    wb.data = aluReg;
			exePkg::WB_LINK:   wb.data = linkReg;
			exePkg::WB_MULDIV: wb.data = mulDivReg;
			exePkg::WB_LUI:    wb.data = uImmReg;
			exePkg::WB_AUIPC:  wb.data = auipcReg;
			default:           wb.data = '0;
		endcase
	end

	wbSelDefined: assert property (@(posedge clk) disable iff (!nrst)
		wb.we |-> wbSelReg inside {exePkg::WB_ALU, exePkg::WB_LINK,
			exePkg::WB_MULDIV, exePkg::WB_LUI, exePkg::WB_AUIPC})
		else $error("resultSelect: write with undefined wbSel %b", wbSelReg);

endmodule

//--- src/memAddrUnit.sv
`include "exeStage_cfg.svh"

module memAddrUnit (
	input logic clk,
	input logic nrst,
	input exePkg::memOp_e memOp,
	input logic [`XLEN-1:0] base,
	input logic [`XLEN-1:0] ldOffset,
	input logic [`XLEN-1:0] sImm,
	input logic [`XLEN-1:0] storeData,
	output exePkg::memReq_t memReq
);

	logic isLoad;
	logic isStore;
	logic isByte;
	logic isHalf;
	logic isWord;
	logic misAl;
	logic [`XLEN-1:0] addr;
	logic [3:0] byteEn;
	exePkg::memReq_t reqNext;

	assign isLoad = memOp inside {exePkg::MEM_LB, exePkg::MEM_LH, exePkg::MEM_LW,
		exePkg::MEM_LBU, exePkg::MEM_LHU};
	assign isStore = memOp inside {exePkg::MEM_SB, exePkg::MEM_SH, exePkg::MEM_SW};

	assign isByte = memOp inside {exePkg::MEM_LB, exePkg::MEM_LBU, exePkg::MEM_SB};
	assign isHalf = memOp inside {exePkg::MEM_LH, exePkg::MEM_LHU, exePkg::MEM_SH};
	assign isWord = memOp inside {exePkg::MEM_LW, exePkg::MEM_SW};

	// stores take the S immediate, loads the I immediate on opB
	assign addr = base + (isStore ? sImm : ldOffset);

	assign misAl = (isHalf & addr[0]) | (isWord & (addr[1:0] != 2'b00));

	always_comb
	begin
		if (misAl)
			byteEn = 4'b0000;
		else if (isByte)
			byteEn = 4'b0001 << addr[1:0];
		else if (isHalf)
			byteEn = 4'b0011 << addr[1:0];
		else if (isWord)
			byteEn = 4'b1111;
		else
			byteEn = 4'b0000; // no access
	end

	always_comb
	begin
		reqNext.valid = isLoad | isStore;
		reqNext.write = isStore;
		reqNext.addr = addr;
		reqNext.wdata = storeData << {addr[1:0], 3'b000}; // byte lane
		reqNext.byteEn = byteEn;
		reqNext.misaligned = misAl;
		reqNext.ldMisaligned = isLoad & misAl;
		reqNext.stMisaligned = isStore & misAl;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			memReq <= '0;
		else
			memReq <= reqNext; // stage 6
	end

	idleNoLanes: assert property (@(posedge clk) disable iff (!nrst)
		!memReq.valid |-> memReq.byteEn == 4'b0000)
		else $error("memAddrUnit: byte enables without a request");

endmodule

//--- src/branchUnit.sv
`include "exeStage_cfg.svh"

module branchUnit (
	input logic [`XLEN-1:0] pc,
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] bImm,
	input logic [`XLEN-1:0] jImm,
	input logic [`XLEN-1:0] iImm,
	input logic isBranch,
	input logic isJal,
	input logic isJalr,
	input logic brTrue,
	input logic valid,
	output logic [`XLEN-1:0] target,
	output logic bjTaken
);

	logic [`XLEN-1:0] jalrSum;

	assign jalrSum = opA + iImm;

	always_comb
	begin
		if (isJal)
			target = pc + jImm;
		else if (isJalr)
			target = {jalrSum[`XLEN-1:1], 1'b0}; // lsb dropped per spec
		else
			target = pc + bImm;
	end

	// jumps always redirect, branches only when the compare holds
	assign bjTaken = valid & (isJal | isJalr | (isBranch & brTrue));

	// decode marks a single control-flow kind per instruction
	oneKind: assert final (!valid || $onehot0({isBranch, isJal, isJalr}))
		else $error("branchUnit: more than one of branch/jal/jalr set");

endmodule

//--- src/mulDiv.sv
`include "exeStage_cfg.svh"

module mulDiv (
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input exePkg::mulDivOp_e mulDivOp,
	output logic [`XLEN-1:0] result
);

	logic aSigned;
	logic bSigned;
	logic signed [`XLEN:0] aExt; // one extra bit carries the sign choice
	logic signed [`XLEN:0] bExt;
	logic signed [2*`XLEN+1:0] product;

	logic divZero;
	logic divOverflow;
	logic [`XLEN-1:0] safeB;
	logic signed [`XLEN-1:0] sQuot;
	logic signed [`XLEN-1:0] sRem;
	logic [`XLEN-1:0] uQuot;
	logic [`XLEN-1:0] uRem;

	assign aSigned = mulDivOp inside {exePkg::MD_MULH, exePkg::MD_MULHSU};
	assign bSigned = mulDivOp == exePkg::MD_MULH;

	assign aExt = {aSigned & opA[`XLEN-1], opA};
	assign bExt = {bSigned & opB[`XLEN-1], opB};
	assign product = aExt * bExt;

	assign divZero = opB == '0;
	// most negative value over -1
	assign divOverflow = (opA == {1'b1, {(`XLEN-1){1'b0}}}) && (opB == '1);

	// keeps the dividers away from a zero divisor
	assign safeB = divZero ? `XLEN'd1 : opB;

	assign sQuot = $signed(opA) / $signed(safeB);
	assign sRem = $signed(opA) % $signed(safeB);
	assign uQuot = opA / safeB;
	assign uRem = opA % safeB;

	always_comb
	begin
		unique case (mulDivOp)
			exePkg::MD_MUL:    result = product[`XLEN-1:0];
			exePkg::MD_MULH,
			exePkg::MD_MULHSU,
			exePkg::MD_MULHU:  result = product[2*`XLEN-1:`XLEN];
			exePkg::MD_DIV:    result = divZero ? '1 : (divOverflow ? opA : sQuot);
			exePkg::MD_DIVU:   result = divZero ? '1 : uQuot;
			exePkg::MD_REM:    result = divZero ? opA : (divOverflow ? '0 : sRem);
			exePkg::MD_REMU:   result = divZero ? opA : uRem;
			default:           result = '0;
		endcase
	end

endmodule

//--- src/alu.sv
`include "exeStage_cfg.svh"

module alu (
	input logic [`XLEN-1:0] opA,
	input logic [`XLEN-1:0] opB,
	input exePkg::aluOp_e aluOp,
	input exePkg::brCond_e brCond,
	output logic [`XLEN-1:0] result,
	output logic brTrue
);

	localparam int ShamtW = $clog2(`XLEN);

	logic [ShamtW-1:0] shamt;
	logic ltSigned;
	logic ltUnsigned;
	logic isEqual;

	assign shamt = opB[ShamtW-1:0];

	// shared by SLT/SLTU and the branch compare
	assign ltSigned = $signed(opA) < $signed(opB);
	assign ltUnsigned = opA < opB;
	assign isEqual = opA == opB;

	always_comb
	begin
		unique case (aluOp)
			exePkg::ALU_ADD:  result = opA + opB;
			exePkg::ALU_SUB:  result = opA - opB;
			exePkg::ALU_SLL:  result = opA << shamt;
			exePkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, ltSigned};
			exePkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, ltUnsigned};
			exePkg::ALU_XOR:  result = opA ^ opB;
			exePkg::ALU_SRL:  result = opA >> shamt;
			exePkg::ALU_SRA:  result = $signed(opA) >>> shamt; // keeps the sign
			exePkg::ALU_OR:   result = opA | opB;
			exePkg::ALU_AND:  result = opA & opB;
			default:          result = '0;
		endcase
	end

	always_comb
	begin
		unique case (brCond)
			exePkg::BR_EQ:  brTrue = isEqual;
			exePkg::BR_NE:  brTrue = !isEqual;
			exePkg::BR_LT:  brTrue = ltSigned;
			exePkg::BR_GE:  brTrue = !ltSigned;
			exePkg::BR_LTU: brTrue = ltUnsigned;
			exePkg::BR_GEU: brTrue = !ltUnsigned;
			default:        brTrue = 1'b0;
		endcase
	end

	// decode must never hand over a reserved funct7/funct3 pair
	aluOpDefined: assert final ($isunknown(aluOp) || aluOp inside {
		exePkg::ALU_ADD, exePkg::ALU_SUB, exePkg::ALU_SLL, exePkg::ALU_SLT,
		exePkg::ALU_SLTU, exePkg::ALU_XOR, exePkg::ALU_SRL, exePkg::ALU_SRA,
		exePkg::ALU_OR, exePkg::ALU_AND})
		else $error("alu: undefined aluOp %b", aluOp);

endmodule

//--- src/exePkg.sv
`include "exeStage_cfg.svh"

package exePkg;

	// {funct7[5], funct3} of the OP/OP-IMM encodings
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} aluOp_e;

	// branch funct3
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} brCond_e;

	// RV32M funct3
	typedef enum logic [2:0] {
		MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
		MD_DIV, MD_DIVU, MD_REM, MD_REMU
	} mulDivOp_e;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
		MEM_SB, MEM_SH, MEM_SW
	} memOp_e;

	typedef enum logic [2:0] {
		WB_ALU, WB_LINK, WB_MULDIV, WB_LUI, WB_AUIPC
	} wbSel_e;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] opA;
		logic [`XLEN-1:0] opB; // rs2 value or I immediate
		logic [`REG_ADDR_W-1:0] rd;
		logic we;
		logic [`XLEN-1:0] pc;
		aluOp_e aluOp;
		wbSel_e wbSel;
		mulDivOp_e mulDivOp;
		memOp_e memOp;
		logic isBranch;
		brCond_e brCond;
		logic isJal;
		logic isJalr;
		logic [`XLEN-1:0] bImm;
		logic [`XLEN-1:0] jImm;
		logic [`XLEN-1:0] uImm;
		logic [`XLEN-1:0] sImm;
	} exeIssue_t;

	typedef struct packed {
		logic we;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0] data;
	} exeResult_t;

	typedef struct packed {
		logic valid;
		logic write;
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] wdata; // already shifted into its byte lane
		logic [3:0] byteEn;
		logic misaligned;
		logic ldMisaligned;
		logic stMisaligned;
	} memReq_t;

endpackage

//--- src/exeStage_cfg.svh
`ifndef EXESTAGE_CFG_SVH
`define EXESTAGE_CFG_SVH

// datapath and address width
`define XLEN 32

// register file index width
`define REG_ADDR_W 5

// link increment for byte-addressed PCs
`define PC_STEP 4

`endif
